/* design/cache_geom_pkg.sv */
// Address split, way and set counts, and tag and LRU list widths of the cache
`default_nettype none

package cache_geom_pkg;

    // Request address is split into a high tag part and a low set index
    localparam int ADDR_BITS = 12;
    localparam int SET_BITS = 6;
    localparam int TAG_BITS = 6;

    // Four ways, addressed by a 2-bit way number
    localparam int WAY_BITS = 2;
    localparam int WAYS = 4;

    // One set per value of the set index
    localparam int SETS = 64;

    // One LRU list holds WAYS slots of WAY_BITS each, slot 0 is the bottom
    localparam int ORDER_BITS = 8;

endpackage

`default_nettype wire

/* design/cache_ctrl_pkg.sv */
// Operation and controller state enums of the tag directory
`default_nettype none

package cache_ctrl_pkg;

    // Operations a requester can send
    typedef enum logic [1:0] {
        OP_LOOKUP,
        OP_INVALIDATE,
        OP_FLUSH
    } cache_op_e;

    // ST_INIT sweeps every set, ST_RESOLVE is the cycle the set data is present
    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_RESOLVE
    } ctrl_state_e;

endpackage

`default_nettype wire

/* design/lru_order_table.sv */
// Per-set LRU order memory with registered read set and init, promote and demote updates
`timescale 1ns/10ps
`default_nettype none

module lru_order_table (
    input  logic                               i_clk,
    input  logic                               i_init,
    input  logic                               i_up,
    input  logic                               i_down,
    input  logic [cache_geom_pkg::SET_BITS-1:0] i_raddr,
    input  logic [cache_geom_pkg::SET_BITS-1:0] i_waddr,
    input  logic [cache_geom_pkg::WAY_BITS-1:0] i_way,
    output logic [cache_geom_pkg::WAY_BITS-1:0] o_lru
);

    localparam int WB = cache_geom_pkg::WAY_BITS;
    localparam int NW = cache_geom_pkg::WAYS;
    localparam int TOP = (NW - 1) * WB;

    logic [cache_geom_pkg::ORDER_BITS-1:0] order_mem [cache_geom_pkg::SETS];
    logic [cache_geom_pkg::SET_BITS-1:0]   raddr_q;

    logic [cache_geom_pkg::ORDER_BITS-1:0] rd_list;
    logic [cache_geom_pkg::ORDER_BITS-1:0] init_list;
    logic [cache_geom_pkg::ORDER_BITS-1:0] up_list;
    logic [cache_geom_pkg::ORDER_BITS-1:0] down_list;
    logic [cache_geom_pkg::ORDER_BITS-1:0] wr_list;
    logic                                  wr_en;

    assign rd_list = order_mem[raddr_q];
    assign wr_en = i_init | i_up | i_down;

    // Bottom slot holds the least recently used way
    assign o_lru = rd_list[WB-1:0];

    always_comb begin
        logic shift_up;
        logic shift_down;

        // Slot k holds way k, so way 0 starts as the victim
        for (int k = 0; k < NW; k++) begin
            init_list[k*WB +: WB] = WB'(k);
        end

        // Promote: slots from the way's old position upward move one slot down
        up_list = rd_list;
        shift_up = 1'b0;
        for (int k = 0; k < NW - 1; k++) begin
            if (rd_list[k*WB +: WB] == i_way) begin
                shift_up = 1'b1;
            end
            if (shift_up) begin
                up_list[k*WB +: WB] = rd_list[(k+1)*WB +: WB];
            end
        end
        up_list[TOP +: WB] = i_way;

        // Demote: slots from the way's old position downward move one slot up
        down_list = rd_list;
        shift_down = 1'b0;
        for (int k = NW - 1; k > 0; k--) begin
            if (rd_list[k*WB +: WB] == i_way) begin
                shift_down = 1'b1;
            end
            if (shift_down) begin
                down_list[k*WB +: WB] = rd_list[(k-1)*WB +: WB];
            end
        end
        down_list[WB-1:0] = i_way;
    end

    // Init wins over up, and up wins over down
    always_comb begin
        if (i_init) begin
            wr_list = init_list;
        end else if (i_up) begin
            wr_list = up_list;
        end else begin
            wr_list = down_list;
        end
    end

    always_ff @(posedge i_clk) begin
        raddr_q <= i_raddr;
        if (wr_en) begin
            order_mem[i_waddr] <= wr_list;
        end
    end

endmodule

`default_nettype wire

/* design/tag_valid_array.sv */
// Per-set, per-way tag and valid storage with registered read set and single-way write
`timescale 1ns/10ps
`default_nettype none

module tag_valid_array (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_we,
    input  logic                                   i_valid,
    input  logic                                   i_clr,
    input  logic [cache_geom_pkg::SET_BITS-1:0]     i_raddr,
    input  logic [cache_geom_pkg::SET_BITS-1:0]     i_waddr,
    input  logic [cache_geom_pkg::WAY_BITS-1:0]     i_way,
    input  logic [cache_geom_pkg::TAG_BITS-1:0]     i_tag,
    output logic [cache_geom_pkg::WAYS*cache_geom_pkg::TAG_BITS-1:0] o_tags,
    output logic [cache_geom_pkg::WAYS-1:0]         o_valids
);

    localparam int TB = cache_geom_pkg::TAG_BITS;
    localparam int LINE_BITS = cache_geom_pkg::WAYS * TB;

    // One entry per set, way w sits at bits [w*TB +: TB]
    logic [LINE_BITS-1:0]                tag_mem [cache_geom_pkg::SETS];
    logic [cache_geom_pkg::WAYS-1:0]     valid_mem [cache_geom_pkg::SETS];
    logic [cache_geom_pkg::SET_BITS-1:0] raddr_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            raddr_q <= '0;
        end else begin
            raddr_q <= i_raddr;
        end
    end

    // A clear of the whole set takes priority over a single-way valid write
    always_ff @(posedge i_clk) begin
        if (i_clr) begin
            valid_mem[i_waddr] <= '0;
        end else if (i_we) begin
            valid_mem[i_waddr][i_way] <= i_valid;
        end
    end

    // The tag is kept on invalidate as well, only the valid bit matters then
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            tag_mem[i_waddr][i_way*TB +: TB] <= i_tag;
        end
    end

    assign o_tags = tag_mem[raddr_q];
    assign o_valids = valid_mem[raddr_q];

endmodule

`default_nettype wire

/* design/tag_dir_controller.sv */
// Controller FSM for init sweep, request acceptance, hit compare, fill and invalidate
`timescale 1ns/10ps
`default_nettype none

module tag_dir_controller (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_req,
    input  cache_ctrl_pkg::cache_op_e              i_op,
    input  logic [cache_geom_pkg::ADDR_BITS-1:0]    i_addr,
    input  logic [cache_geom_pkg::WAYS*cache_geom_pkg::TAG_BITS-1:0] i_tags,
    input  logic [cache_geom_pkg::WAYS-1:0]         i_valids,
    input  logic [cache_geom_pkg::WAY_BITS-1:0]     i_lru,
    output logic [cache_geom_pkg::SET_BITS-1:0]     o_rd_set,
    output logic [cache_geom_pkg::SET_BITS-1:0]     o_wr_set,
    output logic                                   o_lru_init,
    output logic                                   o_lru_up,
    output logic                                   o_lru_down,
    output logic                                   o_tag_we,
    output logic                                   o_tag_valid,
    output logic                                   o_tag_clr,
    output logic [cache_geom_pkg::WAY_BITS-1:0]     o_way,
    output logic [cache_geom_pkg::TAG_BITS-1:0]     o_tag,
    output logic                                   o_ready,
    output logic                                   o_done,
    output logic                                   o_hit,
    output logic [cache_geom_pkg::WAY_BITS-1:0]     o_resp_way
);

    localparam int SB = cache_geom_pkg::SET_BITS;
    localparam int TB = cache_geom_pkg::TAG_BITS;
    localparam int WB = cache_geom_pkg::WAY_BITS;

    cache_ctrl_pkg::ctrl_state_e state_q;
    cache_ctrl_pkg::cache_op_e   op_q;
    logic [SB-1:0]               sweep_q;
    logic [SB-1:0]               set_q;
    logic [TB-1:0]               tag_q;
    logic                        flush_q;
    logic                        done_q;
    logic                        hit_q;
    logic [WB-1:0]               resp_way_q;

    logic                        hit_any;
    logic [WB-1:0]               hit_way;
    logic                        resp_hit;
    logic [WB-1:0]               resp_way;

    assign o_ready = (state_q == cache_ctrl_pkg::ST_IDLE);
    assign o_lru_init = (state_q == cache_ctrl_pkg::ST_INIT);
    assign o_tag_clr = (state_q == cache_ctrl_pkg::ST_INIT);
    assign o_wr_set = (state_q == cache_ctrl_pkg::ST_INIT) ? sweep_q : set_q;
    assign o_tag = tag_q;

    // Read set is taken straight from the request so the data is there in ST_RESOLVE
    always_comb begin
        case (state_q)
            cache_ctrl_pkg::ST_INIT: o_rd_set = sweep_q;
            cache_ctrl_pkg::ST_IDLE: o_rd_set = i_addr[SB-1:0];
            default:                 o_rd_set = set_q;
        endcase
    end

    // Tags are unique within a set, so at most one way can match
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (i_valids[w] && (i_tags[w*TB +: TB] == tag_q)) begin
                hit_any = 1'b1;
                hit_way = WB'(w);
            end
        end
    end

    always_comb begin
        o_lru_up = 1'b0;
        o_lru_down = 1'b0;
        o_tag_we = 1'b0;
        o_tag_valid = 1'b0;
        o_way = '0;
        resp_hit = 1'b0;
        resp_way = '0;
        if (state_q == cache_ctrl_pkg::ST_RESOLVE) begin
            case (op_q)
                cache_ctrl_pkg::OP_LOOKUP: begin
                    // A miss fills the victim and promotes it in the same write
                    o_way = hit_any ? hit_way : i_lru;
                    o_lru_up = 1'b1;
                    o_tag_we = ~hit_any;
                    o_tag_valid = 1'b1;
                    resp_hit = hit_any;
                    resp_way = hit_any ? hit_way : i_lru;
                end
                cache_ctrl_pkg::OP_INVALIDATE: begin
                    if (hit_any) begin
                        o_way = hit_way;
                        o_lru_down = 1'b1;
                        o_tag_we = 1'b1;
                        resp_hit = 1'b1;
                        resp_way = hit_way;
                    end
                end
                default: begin
                    o_way = '0;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= cache_ctrl_pkg::ST_INIT;
            sweep_q <= '0;
            flush_q <= 1'b0;
            done_q <= 1'b0;
            hit_q <= 1'b0;
            resp_way_q <= '0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                cache_ctrl_pkg::ST_INIT: begin
                    sweep_q <= sweep_q + 1'b1;
                    if (sweep_q == SB'(cache_geom_pkg::SETS - 1)) begin
                        // Only a flush reports completion, the reset sweep stays silent
                        state_q <= cache_ctrl_pkg::ST_IDLE;
                        done_q <= flush_q;
                        hit_q <= 1'b0;
                        resp_way_q <= '0;
                        flush_q <= 1'b0;
                    end
                end
                cache_ctrl_pkg::ST_IDLE: begin
                    if (i_req) begin
                        if (i_op == cache_ctrl_pkg::OP_FLUSH) begin
                            state_q <= cache_ctrl_pkg::ST_INIT;
                            sweep_q <= '0;
                            flush_q <= 1'b1;
                        end else begin
                            state_q <= cache_ctrl_pkg::ST_RESOLVE;
                        end
                    end
                end
                cache_ctrl_pkg::ST_RESOLVE: begin
                    state_q <= cache_ctrl_pkg::ST_IDLE;
                    done_q <= 1'b1;
                    hit_q <= resp_hit;
                    resp_way_q <= resp_way;
                end
                default: begin
                    state_q <= cache_ctrl_pkg::ST_INIT;
                    sweep_q <= '0;
                end
            endcase
        end
    end

    // Request fields are captured at acceptance and held through ST_RESOLVE
    always_ff @(posedge i_clk) begin
        if (o_ready && i_req) begin
            op_q <= i_op;
            set_q <= i_addr[SB-1:0];
            tag_q <= i_addr[cache_geom_pkg::ADDR_BITS-1 -: TB];
        end
    end

    assign o_done = done_q;
    assign o_hit = hit_q;
    assign o_resp_way = resp_way_q;

endmodule

`default_nettype wire

/* design/tag_dir_top.sv */
// Tag directory top level connecting the controller to the tag/valid and LRU arrays
`timescale 1ns/10ps
`default_nettype none

module tag_dir_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_req,
    input  cache_ctrl_pkg::cache_op_e           i_op,
    input  logic [cache_geom_pkg::ADDR_BITS-1:0] i_addr,
    output logic                                o_ready,
    output logic                                o_done,
    output logic                                o_hit,
    output logic [cache_geom_pkg::WAY_BITS-1:0]  o_way
);

    logic [cache_geom_pkg::WAYS*cache_geom_pkg::TAG_BITS-1:0] tags;
    logic [cache_geom_pkg::WAYS-1:0]     valids;
    logic [cache_geom_pkg::WAY_BITS-1:0] lru_way;
    logic [cache_geom_pkg::SET_BITS-1:0] rd_set;
    logic [cache_geom_pkg::SET_BITS-1:0] wr_set;
    logic                                lru_init;
    logic                                lru_up;
    logic                                lru_down;
    logic                                tag_we;
    logic                                tag_valid;
    logic                                tag_clr;
    logic [cache_geom_pkg::WAY_BITS-1:0] upd_way;
    logic [cache_geom_pkg::TAG_BITS-1:0] upd_tag;

    tag_dir_controller u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_op        (i_op),
        .i_addr      (i_addr),
        .i_tags      (tags),
        .i_valids    (valids),
        .i_lru       (lru_way),
        .o_rd_set    (rd_set),
        .o_wr_set    (wr_set),
        .o_lru_init  (lru_init),
        .o_lru_up    (lru_up),
        .o_lru_down  (lru_down),
        .o_tag_we    (tag_we),
        .o_tag_valid (tag_valid),
        .o_tag_clr   (tag_clr),
        .o_way       (upd_way),
        .o_tag       (upd_tag),
        .o_ready     (o_ready),
        .o_done      (o_done),
        .o_hit       (o_hit),
        .o_resp_way  (o_way)
    );

    tag_valid_array u_tags (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (tag_we),
        .i_valid  (tag_valid),
        .i_clr    (tag_clr),
        .i_raddr  (rd_set),
        .i_waddr  (wr_set),
        .i_way    (upd_way),
        .i_tag    (upd_tag),
        .o_tags   (tags),
        .o_valids (valids)
    );

    lru_order_table u_lru (
        .i_clk   (i_clk),
        .i_init  (lru_init),
        .i_up    (lru_up),
        .i_down  (lru_down),
        .i_raddr (rd_set),
        .i_waddr (wr_set),
        .i_way   (upd_way),
        .o_lru   (lru_way)
    );

endmodule

`default_nettype wire

/* tb/tag_dir_checker.sv */
// Reference model of tags, valid bits and LRU lists that checks every tag directory response
`timescale 1ns/10ps
`default_nettype none

module tag_dir_checker (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_req,
    input  cache_ctrl_pkg::cache_op_e            i_op,
    input  logic [cache_geom_pkg::ADDR_BITS-1:0] i_addr,
    input  logic                                 i_ready,
    input  logic                                 i_done,
    input  logic                                 i_hit,
    input  logic [cache_geom_pkg::WAY_BITS-1:0]  i_way,
    input  logic                                 i_exp_en,
    input  logic                                 i_exp_hit,
    input  logic [cache_geom_pkg::WAY_BITS-1:0]  i_exp_way,
    output int                                   o_pass_count,
    output int                                   o_fail_count
);

    localparam int SB = cache_geom_pkg::SET_BITS;
    localparam int TB = cache_geom_pkg::TAG_BITS;
    localparam int WB = cache_geom_pkg::WAY_BITS;
    localparam int NW = cache_geom_pkg::WAYS;
    localparam int NS = cache_geom_pkg::SETS;

    // Slot 0 of each order list is the least recently used way
    logic [TB-1:0]  tag_m [NS][NW];
    logic           valid_m [NS][NW];
    int             order_m [NS][NW];

    logic                              busy;
    int                                test_num;
    cache_ctrl_pkg::cache_op_e         cur_op;
    logic [cache_geom_pkg::ADDR_BITS-1:0] cur_addr;
    logic                              pred_hit;
    logic [WB-1:0]                     pred_way;
    logic                              tab_en;
    logic                              tab_hit;
    logic [WB-1:0]                     tab_way;

    task automatic clear_model();
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                valid_m[s][w] = 1'b0;
                order_m[s][w] = w;
            end
        end
    endtask

    task automatic move_to_top(input int s, input int w);
        int p;
        p = 0;
        for (int k = 0; k < NW; k++) begin
            if (order_m[s][k] == w) p = k;
        end
        for (int k = p; k < NW - 1; k++) begin
            order_m[s][k] = order_m[s][k+1];
        end
        order_m[s][NW-1] = w;
    endtask

    task automatic move_to_bottom(input int s, input int w);
        int p;
        p = 0;
        for (int k = 0; k < NW; k++) begin
            if (order_m[s][k] == w) p = k;
        end
        for (int k = p; k > 0; k--) begin
            order_m[s][k] = order_m[s][k-1];
        end
        order_m[s][0] = w;
    endtask

    // Applies one accepted operation to the model and records the response it predicts
    task automatic predict(input cache_ctrl_pkg::cache_op_e op,
                           input logic [cache_geom_pkg::ADDR_BITS-1:0] addr);
        int s;
        int hw;
        int vic;
        logic [TB-1:0] t;
        s = int'(addr[SB-1:0]);
        t = addr[cache_geom_pkg::ADDR_BITS-1 -: TB];
        hw = -1;
        pred_hit = 1'b0;
        pred_way = '0;
        for (int w = 0; w < NW; w++) begin
            if (valid_m[s][w] && tag_m[s][w] == t) hw = w;
        end
        case (op)
            cache_ctrl_pkg::OP_LOOKUP: begin
                if (hw >= 0) begin
                    pred_hit = 1'b1;
                    pred_way = WB'(hw);
                    move_to_top(s, hw);
                end else begin
                    vic = order_m[s][0];
                    tag_m[s][vic] = t;
                    valid_m[s][vic] = 1'b1;
                    pred_way = WB'(vic);
                    move_to_top(s, vic);
                end
            end
            cache_ctrl_pkg::OP_INVALIDATE: begin
                if (hw >= 0) begin
                    pred_hit = 1'b1;
                    pred_way = WB'(hw);
                    valid_m[s][hw] = 1'b0;
                    move_to_bottom(s, hw);
                end
            end
            default: clear_model();
        endcase
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            clear_model();
            busy = 1'b0;
            test_num = 0;
            o_pass_count = 0;
            o_fail_count = 0;
        end else begin
            if (i_done) begin
                if (!busy) begin
                    $display("Done pulse at time %0t with no request outstanding", $time);
                    o_fail_count = o_fail_count + 1;
                end else if (tab_en && (tab_hit != pred_hit || tab_way != pred_way)) begin
                    $display("Table entry of test %0d disagrees with the reference model",
                             test_num);
                    o_fail_count = o_fail_count + 1;
                end else if (i_hit != pred_hit || i_way != pred_way) begin
                    $display("Fail at %0t: test %0d %s addr %03h %s",
                             $time, test_num, cur_op.name(), cur_addr,
                             $sformatf("expected hit %0b way %0d, got hit %0b way %0d",
                                       pred_hit, pred_way, i_hit, i_way));
                    o_fail_count = o_fail_count + 1;
                end else begin
                    $display("Test %0d %s addr %03h: hit %0b way %0d ok",
                             test_num, cur_op.name(), cur_addr, i_hit, i_way);
                    o_pass_count = o_pass_count + 1;
                end
                busy = 1'b0;
            end else if (busy && i_ready) begin
                $display("Ready went high at time %0t while test %0d was still in flight",
                         $time, test_num);
                o_fail_count = o_fail_count + 1;
            end
            if (i_req && i_ready) begin
                test_num = test_num + 1;
                cur_op = i_op;
                cur_addr = i_addr;
                tab_en = i_exp_en;
                tab_hit = i_exp_hit;
                tab_way = i_exp_way;
                predict(i_op, i_addr);
                busy = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_tag_dir.sv */
// Tag directory testbench with clock, reset, operation table, LFSR random phase and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_tag_dir;

    localparam int TABLE_LEN = 25;
    localparam int RAND_OPS = 40;
    localparam int NUM_OPS = TABLE_LEN + RAND_OPS;
    localparam int CYCLE_LIMIT = 8 * NUM_OPS + 3 * cache_geom_pkg::SETS;

    typedef struct packed {
        cache_ctrl_pkg::cache_op_e            op;
        logic [cache_geom_pkg::ADDR_BITS-1:0] addr;
        logic                                 hit;
        logic [cache_geom_pkg::WAY_BITS-1:0]  way;
    } table_entry_t;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 req;
    cache_ctrl_pkg::cache_op_e            op;
    logic [cache_geom_pkg::ADDR_BITS-1:0] addr;
    logic                                 exp_en;
    logic                                 exp_hit;
    logic [cache_geom_pkg::WAY_BITS-1:0]  exp_way;
    logic                                 ready;
    logic                                 done;
    logic                                 hit;
    logic [cache_geom_pkg::WAY_BITS-1:0]  way;
    int                                   pass_count;
    int                                   fail_count;
    int                                   cycle_count = 0;
    logic [7:0]                           lfsr_q;
    table_entry_t                         tbl [TABLE_LEN];

    tag_dir_top dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_req   (req),
        .i_op    (op),
        .i_addr  (addr),
        .o_ready (ready),
        .o_done  (done),
        .o_hit   (hit),
        .o_way   (way)
    );

    tag_dir_checker u_checker (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_req        (req),
        .i_op         (op),
        .i_addr       (addr),
        .i_ready      (ready),
        .i_done       (done),
        .i_hit        (hit),
        .i_way        (way),
        .i_exp_en     (exp_en),
        .i_exp_hit    (exp_hit),
        .i_exp_way    (exp_way),
        .o_pass_count (pass_count),
        .o_fail_count (fail_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stalled: no done pulse after %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Galois LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 8'hB8;
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Address is {tag, set} and list comments give the set order from bottom to top
    task automatic load_table();
        // Set 5 fills ways 0 to 3 and then sees hits and evictions
        tbl[0]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h045, 1'b0, 2'd0};
        tbl[1]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h085, 1'b0, 2'd1};
        tbl[2]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h0C5, 1'b0, 2'd2};
        tbl[3]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h105, 1'b0, 2'd3};
        tbl[4]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h045, 1'b1, 2'd0};
        tbl[5]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h0C5, 1'b1, 2'd2};
        // Order is now 1 3 0 2 so way 1 and then way 3 are evicted
        tbl[6]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h145, 1'b0, 2'd1};
        tbl[7]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h085, 1'b0, 2'd3};
        tbl[8]  = '{cache_ctrl_pkg::OP_LOOKUP,     12'h145, 1'b1, 2'd1};
        // Invalidated way drops to the bottom and is refilled first
        tbl[9]  = '{cache_ctrl_pkg::OP_INVALIDATE, 12'h0C5, 1'b1, 2'd2};
        tbl[10] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h0C5, 1'b0, 2'd2};
        tbl[11] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h045, 1'b1, 2'd0};
        // Order is 3 1 2 0 and an invalidate that misses keeps way 3 as the victim
        tbl[12] = '{cache_ctrl_pkg::OP_INVALIDATE, 12'h185, 1'b0, 2'd0};
        tbl[13] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h185, 1'b0, 2'd3};
        tbl[14] = '{cache_ctrl_pkg::OP_INVALIDATE, 12'h1A7, 1'b0, 2'd0};
        tbl[15] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h027, 1'b0, 2'd0};
        tbl[16] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h027, 1'b1, 2'd0};
        tbl[17] = '{cache_ctrl_pkg::OP_INVALIDATE, 12'h027, 1'b1, 2'd0};
        tbl[18] = '{cache_ctrl_pkg::OP_INVALIDATE, 12'h027, 1'b0, 2'd0};
        // After the flush every set starts again from way 0
        tbl[19] = '{cache_ctrl_pkg::OP_FLUSH,      12'h000, 1'b0, 2'd0};
        tbl[20] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h045, 1'b0, 2'd0};
        tbl[21] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h145, 1'b0, 2'd1};
        tbl[22] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h027, 1'b0, 2'd0};
        tbl[23] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h0C5, 1'b0, 2'd2};
        tbl[24] = '{cache_ctrl_pkg::OP_LOOKUP,     12'h045, 1'b1, 2'd0};
    endtask

    // Waits for ready, strobes one request on a falling edge, then waits for done
    task automatic run_op(input cache_ctrl_pkg::cache_op_e t_op,
                          input logic [cache_geom_pkg::ADDR_BITS-1:0] t_addr,
                          input logic t_exp_en, input logic t_exp_hit,
                          input logic [cache_geom_pkg::WAY_BITS-1:0] t_exp_way);
        while (!ready) @(negedge clk);
        req = 1'b1;
        op = t_op;
        addr = t_addr;
        exp_en = t_exp_en;
        exp_hit = t_exp_hit;
        exp_way = t_exp_way;
        @(negedge clk);
        req = 1'b0;
        while (!done) @(negedge clk);
    endtask

    initial begin
        logic [7:0] op_bits;
        logic [7:0] tag_bits;
        logic [7:0] set_bit;
        cache_ctrl_pkg::cache_op_e rand_op;
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        op = cache_ctrl_pkg::OP_LOOKUP;
        addr = '0;
        exp_en = 1'b0;
        exp_hit = 1'b0;
        exp_way = '0;
        lfsr_q = 8'd37;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < TABLE_LEN; i++) begin
            run_op(tbl[i].op, tbl[i].addr, 1'b1, tbl[i].hit, tbl[i].way);
        end
        // Random tags in sets 5 and 7 with about a quarter of them invalidates
        for (int i = 0; i < RAND_OPS; i++) begin
            take_bits(2, op_bits);
            take_bits(3, tag_bits);
            take_bits(1, set_bit);
            rand_op = (op_bits[1:0] == 2'b11) ? cache_ctrl_pkg::OP_INVALIDATE
                                               : cache_ctrl_pkg::OP_LOOKUP;
            run_op(rand_op, {3'b000, tag_bits[2:0], (set_bit[0] ? 6'd7 : 6'd5)},
                   1'b0, 1'b0, 2'd0);
        end
        @(negedge clk);
        $display("Tests run %0d, passed %0d, failed %0d", NUM_OPS, pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_OPS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/cache_geom_pkg.sv
design/cache_ctrl_pkg.sv
design/lru_order_table.sv
design/tag_valid_array.sv
design/tag_dir_controller.sv
design/tag_dir_top.sv
tb/tag_dir_checker.sv
tb/tb_tag_dir.sv

/* run_sim.sh */
#!/bin/sh
# Build the tag directory testbench with Verilator, run it and search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_tag_dir -f filelist.f -o tb_tag_dir \
    && ./obj_dir/tb_tag_dir > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log 2>/dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
